//--- files.f
logic/lbm_pkg.sv
logic/lbm_config.sv
logic/lbm_sequencer.sv
logic/lbm_stream_map.sv
logic/lbm_lattice.sv
logic/lbm_top.sv
tests/lbm_tb_sva.sv
tests/lbm_tb.sv

//--- logic/lbm_config.sv
`timescale 1ns/1ps

module lbm_config (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cfg_strobe,
    input  lbm_pkg::cfg_t        cfg,
    input  logic                 busy,
    input  logic                 step_done,
    output lbm_pkg::dist_vec_t   init_vec,
    output logic                 init_req,
    output logic                 run_req,
    output lbm_pkg::step_cnt_t   step_count
);
    import lbm_pkg::*;

    step_cnt_t step_target;
    logic      accept;

    // Strobes arriving mid-run are dropped
    assign accept   = cfg_strobe && !busy;
    assign init_req = accept;

    // Keep stepping until the counter reaches the target
    assign run_req = (step_count < step_target);

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            step_target <= '0;
            step_count  <= '0;
        end
        else if (accept)
        begin
            step_target <= cfg.step_target;
            step_count  <= '0;
        end
        else if (step_done)
        begin
            step_count <= step_count + 1'b1;
        end
    end

    // Init vector is held for the whole INIT sweep
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            init_vec <= cfg.init_vec;
        end
    end

endmodule

//--- logic/lbm_lattice.sv
`timescale 1ns/1ps

module lbm_lattice #(
    parameter int GRID_W = 8,
    parameter int GRID_H = 8,
    parameter int ADDR_W = 6,
    parameter type wr_set_t = logic
) (
    input  logic                 clk,
    input  logic                 rst,
    input  wr_set_t              wr,
    input  logic [ADDR_W-1:0]    rd_addr,
    input  logic                 swap,
    input  logic [ADDR_W-1:0]    obs_addr,
    output lbm_pkg::dist_vec_t   cur_rd,
    output lbm_pkg::dist_vec_t   nxt_rd,
    output lbm_pkg::dist_vec_t   obs_data
);
    import lbm_pkg::*;

    localparam int DEPTH = GRID_W * GRID_H;

    // Physical bank 0 is current while bank_sel is low
    logic        bank_sel;
    logic        wr_both;
    logic        wr_cur;
    dist_t [8:0] cur_a;
    dist_t [8:0] nxt_a;
    dist_t [8:0] obs_a;

    assign wr_both = (wr.bank == BANK_BOTH);
    assign wr_cur  = (wr.bank == BANK_CUR);

    assign cur_rd   = cur_a;
    assign nxt_rd   = nxt_a;
    assign obs_data = obs_a;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            bank_sel <= 1'b0;
        end
        else if (swap)
        begin
            bank_sel <= !bank_sel;
        end
    end

    ////////////////////////////////////////
    // One memory pair per direction
    ////////////////////////////////////////

    for (genvar d = 0; d < 9; d++)
    begin : g_dir
        dist_t      mem [2][DEPTH];
        logic [1:0] we;
        dist_t      cur_q;
        dist_t      nxt_q;
        dist_t      obs_q;

        // Logical bank resolved against the select in the write cycle
        assign we[0] = wr.req[d].en && (wr_both || (wr_cur == !bank_sel));
        assign we[1] = wr.req[d].en && (wr_both || (wr_cur == bank_sel));

        always_ff @(posedge clk)
        begin
            for (int b = 0; b < 2; b++)
            begin
                if (we[b])
                begin
                    mem[b][wr.req[d].addr] <= wr.req[d].data;
                end
            end
            cur_q <= mem[bank_sel][rd_addr];
            nxt_q <= mem[!bank_sel][rd_addr];
            obs_q <= mem[bank_sel][obs_addr];
        end

        assign cur_a[d] = cur_q;
        assign nxt_a[d] = nxt_q;
        assign obs_a[d] = obs_q;
    end

endmodule

//--- logic/lbm_pkg.sv
package lbm_pkg;

    ////////////////////////////////////////
    // Data types
    ////////////////////////////////////////

    // One fixed-point distribution value
    typedef logic [15:0] dist_t;

    // D2Q9 directions clockwise from north after the rest direction
    typedef enum logic [3:0] {
        DIR_0,
        DIR_N,
        DIR_NE,
        DIR_E,
        DIR_SE,
        DIR_S,
        DIR_SW,
        DIR_W,
        DIR_NW
    } dir_e;

    // Rest direction sits in the low bits so the vector indexes like dir_e
    typedef struct packed {
        dist_t f_nw;
        dist_t f_w;
        dist_t f_sw;
        dist_t f_s;
        dist_t f_se;
        dist_t f_e;
        dist_t f_ne;
        dist_t f_n;
        dist_t f_0;
    } dist_vec_t;

    typedef enum logic [2:0] {
        MAP_NONE,
        MAP_INIT,
        MAP_STREAM,
        MAP_BOUNCE,
        MAP_ZERO
    } map_op_e;

    typedef enum logic [1:0] {
        BANK_CUR,
        BANK_NXT,
        BANK_BOTH
    } bank_e;

    typedef enum logic [2:0] {
        IDLE,
        INIT,
        STREAM,
        STREAM_WAIT,
        BOUNCE,
        BOUNCE_WAIT,
        ZERO,
        SWAP
    } sweep_state_e;

    typedef logic [15:0] step_cnt_t;

    typedef struct packed {
        dist_vec_t init_vec;
        step_cnt_t step_target;
    } cfg_t;

    ////////////////////////////////////////
    // Constants
    ////////////////////////////////////////

    localparam int RAM_READ_WAIT = 1;

    // Horizontal step of each direction
    localparam int DIR_DX [9] = '{0, 0, 1, 1, 1, 0, -1, -1, -1};

    // Reflected direction for bounce-back
    localparam dir_e DIR_OPP [9] = '{
        DIR_0, DIR_S, DIR_SW, DIR_W, DIR_NW, DIR_N, DIR_NE, DIR_E, DIR_SE
    };

endpackage

//--- logic/lbm_sequencer.sv
`timescale 1ns/1ps

module lbm_sequencer #(
    parameter int GRID_W = 8,
    parameter int GRID_H = 8,
    parameter int ADDR_W = 6,
    localparam int COL_W = $clog2(GRID_W)
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       init_req,
    input  logic                       run_req,
    input  logic [GRID_W*GRID_H-1:0]   barriers,
    output logic [ADDR_W-1:0]          cell_addr,
    output logic [COL_W-1:0]           col,
    output lbm_pkg::map_op_e           map_op,
    output logic [ADDR_W-1:0]          rd_addr,
    output logic                       swap,
    output logic                       step_done,
    output logic                       busy
);
    import lbm_pkg::*;

    ////////////////////////////////////////
    // Sweep bounds
    ////////////////////////////////////////

    localparam logic [ADDR_W-1:0] LAST_CELL    = ADDR_W'(GRID_W * GRID_H - 1);
    localparam logic [ADDR_W-1:0] STREAM_FIRST = ADDR_W'(GRID_W + 1);
    localparam logic [ADDR_W-1:0] STREAM_LAST  = ADDR_W'((GRID_H - 1) * GRID_W - 2);
    localparam logic [ADDR_W-1:0] BOUNCE_FIRST = ADDR_W'(2 * GRID_W + 2);
    localparam logic [ADDR_W-1:0] BOUNCE_LAST  = ADDR_W'((GRID_H - 2) * GRID_W - 3);

    localparam logic [COL_W-1:0] COL_LAST       = COL_W'(GRID_W - 1);
    localparam logic [COL_W-1:0] STREAM_COL_END = COL_W'(GRID_W - 2);
    localparam logic [COL_W-1:0] BOUNCE_COL_END = COL_W'(GRID_W - 3);

    // Wait states count down to zero, then issue the write
    localparam logic [1:0] WAIT_LOAD = 2'(RAM_READ_WAIT - 1);

    sweep_state_e      state;
    sweep_state_e      state_nxt;
    logic [ADDR_W-1:0] idx;
    logic [ADDR_W-1:0] idx_nxt;
    logic [COL_W-1:0]  col_nxt;
    logic [1:0]        wait_cnt;
    logic [1:0]        wait_nxt;
    logic              barrier_here;
    logic              next_stream;
    logic              next_bounce;
    logic              wr_pending;

    assign barrier_here = barriers[idx];
    assign cell_addr    = idx;
    assign rd_addr      = idx;

    assign step_done = (state == SWAP);
    assign swap      = (state == SWAP);

    // Held high between steps while more remain and until the last write lands
    assign busy = (state != IDLE) || run_req || wr_pending;

    ////////////////////////////////////////
    // Next state
    ////////////////////////////////////////

    always_comb
    begin
        state_nxt   = state;
        idx_nxt     = idx;
        col_nxt     = col;
        wait_nxt    = wait_cnt;
        map_op      = MAP_NONE;
        next_stream = 1'b0;
        next_bounce = 1'b0;

        case (state)
            IDLE:
            begin
                if (init_req)
                begin
                    state_nxt = INIT;
                    idx_nxt   = '0;
                    col_nxt   = '0;
                end
                else if (run_req)
                begin
                    state_nxt = STREAM;
                    idx_nxt   = STREAM_FIRST;
                    col_nxt   = COL_W'(1);
                end
            end

            INIT, ZERO:
            begin
                if (state == INIT)
                begin
                    map_op = MAP_INIT;
                end
                else if (barrier_here)
                begin
                    map_op = MAP_ZERO;
                end

                if (idx == LAST_CELL)
                begin
                    state_nxt = (state == INIT) ? IDLE : SWAP;
                end
                else
                begin
                    idx_nxt = idx + 1'b1;
                    col_nxt = (col == COL_LAST) ? '0 : col + 1'b1;
                end
            end

            STREAM:
            begin
                // Barrier cells hold nothing to push
                if (!barrier_here)
                begin
                    state_nxt = STREAM_WAIT;
                    wait_nxt  = WAIT_LOAD;
                end
                else
                begin
                    next_stream = 1'b1;
                end
            end

            STREAM_WAIT:
            begin
                if (wait_cnt != '0)
                begin
                    wait_nxt = wait_cnt - 1'b1;
                end
                else
                begin
                    map_op      = MAP_STREAM;
                    next_stream = 1'b1;
                end
            end

            BOUNCE:
            begin
                // Only barriers need their next-bank values read
                if (barrier_here)
                begin
                    state_nxt = BOUNCE_WAIT;
                    wait_nxt  = WAIT_LOAD;
                end
                else
                begin
                    next_bounce = 1'b1;
                end
            end

            BOUNCE_WAIT:
            begin
                if (wait_cnt != '0)
                begin
                    wait_nxt = wait_cnt - 1'b1;
                end
                else
                begin
                    map_op      = MAP_BOUNCE;
                    next_bounce = 1'b1;
                end
            end

            SWAP:
            begin
                state_nxt = IDLE;
            end

            default:
            begin
                state_nxt = IDLE;
            end
        endcase

        // Stream region skips the outer ring with a jump of three cells at each row end
        if (next_stream)
        begin
            if (idx == STREAM_LAST)
            begin
                state_nxt = BOUNCE;
                idx_nxt   = BOUNCE_FIRST;
                col_nxt   = COL_W'(2);
            end
            else
            begin
                state_nxt = STREAM;
                idx_nxt   = (col == STREAM_COL_END) ? idx + ADDR_W'(3) : idx + 1'b1;
                col_nxt   = (col == STREAM_COL_END) ? COL_W'(1) : col + 1'b1;
            end
        end

        // Inner region keeps a two-cell margin and jumps five cells at each row end
        if (next_bounce)
        begin
            if (idx == BOUNCE_LAST)
            begin
                state_nxt = ZERO;
                idx_nxt   = '0;
                col_nxt   = '0;
            end
            else
            begin
                state_nxt = BOUNCE;
                idx_nxt   = (col == BOUNCE_COL_END) ? idx + ADDR_W'(5) : idx + 1'b1;
                col_nxt   = (col == BOUNCE_COL_END) ? COL_W'(2) : col + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state      <= IDLE;
            idx        <= '0;
            col        <= '0;
            wait_cnt   <= '0;
            wr_pending <= 1'b0;
        end
        else
        begin
            state      <= state_nxt;
            idx        <= idx_nxt;
            col        <= col_nxt;
            wait_cnt   <= wait_nxt;
            wr_pending <= (map_op != MAP_NONE);
        end
    end

endmodule

//--- logic/lbm_stream_map.sv
`timescale 1ns/1ps

module lbm_stream_map #(
    parameter int GRID_W = 8,
    parameter int ADDR_W = 6,
    parameter type wr_set_t = logic,
    localparam int COL_W = $clog2(GRID_W)
) (
    input  logic                 clk,
    input  logic                 rst,
    input  lbm_pkg::map_op_e     map_op,
    input  logic [ADDR_W-1:0]    cell_addr,
    input  logic [COL_W-1:0]     col,
    input  lbm_pkg::dist_vec_t   init_vec,
    input  logic                 barrier_here,
    input  lbm_pkg::dist_vec_t   cur_rd,
    input  lbm_pkg::dist_vec_t   nxt_rd,
    output wr_set_t              wr
);
    import lbm_pkg::*;

    // Neighbor address offset per direction
    localparam int DIR_OFS [9] = '{
        0, -GRID_W, 1 - GRID_W, 1, GRID_W + 1, GRID_W, GRID_W - 1, -1, -GRID_W - 1
    };

    localparam logic [COL_W-1:0] COL_LAST = COL_W'(GRID_W - 1);

    dist_t [8:0] init_a;
    dist_t [8:0] cur_a;
    dist_t [8:0] nxt_a;
    logic  [8:0] wrap;
    wr_set_t     wr_nxt;

    assign init_a = init_vec;
    assign cur_a  = cur_rd;
    assign nxt_a  = nxt_rd;

    // A neighbor write off either row end would land on the adjacent row
    always_comb
    begin
        for (int d = 0; d < 9; d++)
        begin
            wrap[d] = (DIR_DX[d] > 0 && col == COL_LAST) || (DIR_DX[d] < 0 && col == '0);
        end
    end

    always_comb
    begin
        wr_nxt = '0;
        wr_nxt.bank = BANK_NXT;

        for (int d = 0; d < 9; d++)
        begin
            case (map_op)
                MAP_INIT:
                begin
                    wr_nxt.req[d].en   = 1'b1;
                    wr_nxt.req[d].addr = cell_addr;
                    wr_nxt.req[d].data = barrier_here ? '0 : init_a[d];
                end
                MAP_STREAM:
                begin
                    wr_nxt.req[d].en   = !wrap[d];
                    wr_nxt.req[d].addr = cell_addr + ADDR_W'(DIR_OFS[d]);
                    wr_nxt.req[d].data = cur_a[d];
                end
                MAP_BOUNCE:
                begin
                    // Rest component does not move
                    wr_nxt.req[d].en   = (d != 0) && !wrap[d];
                    wr_nxt.req[d].addr = cell_addr + ADDR_W'(DIR_OFS[d]);
                    wr_nxt.req[d].data = nxt_a[DIR_OPP[d]];
                end
                MAP_ZERO:
                begin
                    wr_nxt.req[d].en   = 1'b1;
                    wr_nxt.req[d].addr = cell_addr;
                end
                default:
                begin
                    wr_nxt.req[d].en = 1'b0;
                end
            endcase
        end

        if (map_op == MAP_INIT)
        begin
            wr_nxt.bank = BANK_BOTH;
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            wr <= '0;
        end
        else
        begin
            wr <= wr_nxt;
        end
    end

endmodule

//--- logic/lbm_top.sv
`timescale 1ns/1ps

module lbm_top #(
    parameter int GRID_W = 8,
    parameter int GRID_H = 8,
    parameter int ADDR_W = 6
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cfg_strobe,
    input  lbm_pkg::cfg_t              cfg,
    input  logic [GRID_W*GRID_H-1:0]   barriers,
    input  logic [ADDR_W-1:0]          obs_addr,
    output lbm_pkg::dist_vec_t         obs_data,
    output logic                       busy,
    output logic                       step_done,
    output lbm_pkg::step_cnt_t         step_count
);
    import lbm_pkg::*;

    // Per-direction write request shared by the map and the memory
    typedef struct packed {
        logic              en;
        logic [ADDR_W-1:0] addr;
        dist_t             data;
    } wr_req_t;

    typedef struct packed {
        wr_req_t [8:0] req;
        bank_e         bank;
    } wr_set_t;

    dist_vec_t                   init_vec;
    logic                        init_req;
    logic                        run_req;
    logic [ADDR_W-1:0]           cell_addr;
    logic [ADDR_W-1:0]           rd_addr;
    logic [$clog2(GRID_W)-1:0]   col;
    map_op_e                     map_op;
    logic                        swap;
    logic                        barrier_here;
    dist_vec_t                   cur_rd;
    dist_vec_t                   nxt_rd;
    wr_set_t                     wr;

    assign barrier_here = barriers[cell_addr];

    lbm_config i_config (
        .clk        (clk),
        .rst        (rst),
        .cfg_strobe (cfg_strobe),
        .cfg        (cfg),
        .busy       (busy),
        .step_done  (step_done),
        .init_vec   (init_vec),
        .init_req   (init_req),
        .run_req    (run_req),
        .step_count (step_count)
    );

    lbm_sequencer #(.GRID_W(GRID_W), .GRID_H(GRID_H), .ADDR_W(ADDR_W)) i_sequencer (
        .clk       (clk),
        .rst       (rst),
        .init_req  (init_req),
        .run_req   (run_req),
        .barriers  (barriers),
        .cell_addr (cell_addr),
        .col       (col),
        .map_op    (map_op),
        .rd_addr   (rd_addr),
        .swap      (swap),
        .step_done (step_done),
        .busy      (busy)
    );

    lbm_stream_map #(.GRID_W(GRID_W), .ADDR_W(ADDR_W), .wr_set_t(wr_set_t)) i_stream_map (
        .clk          (clk),
        .rst          (rst),
        .map_op       (map_op),
        .cell_addr    (cell_addr),
        .col          (col),
        .init_vec     (init_vec),
        .barrier_here (barrier_here),
        .cur_rd       (cur_rd),
        .nxt_rd       (nxt_rd),
        .wr           (wr)
    );

    lbm_lattice #(
        .GRID_W   (GRID_W),
        .GRID_H   (GRID_H),
        .ADDR_W   (ADDR_W),
        .wr_set_t (wr_set_t)
    ) i_lattice (
        .clk      (clk),
        .rst      (rst),
        .wr       (wr),
        .rd_addr  (rd_addr),
        .swap     (swap),
        .obs_addr (obs_addr),
        .cur_rd   (cur_rd),
        .nxt_rd   (nxt_rd),
        .obs_data (obs_data)
    );

endmodule

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module lbm_tb -f files.f -o lbm_sim

./obj_dir/lbm_sim | tee sim.log

if grep -q "TEST PASS" sim.log
then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

//--- tests/lbm_tb.sv
`timescale 1ns/1ps

module lbm_tb;
    import lbm_pkg::*;

    localparam int GRID_W = 8;
    localparam int GRID_H = 8;
    localparam int ADDR_W = 6;
    localparam int CELLS  = GRID_W * GRID_H;

    ////////////////////////////////////////
    // Run length budget in cycles
    ////////////////////////////////////////

    localparam int INIT_CYCLES = CELLS;
    localparam int STREAM_CYC  = 2 * (GRID_W - 2) * (GRID_H - 2);
    localparam int BOUNCE_CYC  = 2 * (GRID_W - 4) * (GRID_H - 4);
    localparam int STEP_CYCLES = STREAM_CYC + BOUNCE_CYC + CELLS + 4;
    localparam int READ_CYCLES = 2 * CELLS;
    localparam int TEST_STEPS  = 5;
    localparam int TEST_CYCLES = 4 * (INIT_CYCLES + READ_CYCLES + 20) + TEST_STEPS * STEP_CYCLES;
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

    // Row and column step of each direction in dir_e order
    localparam int DR [9] = '{0, -1, -1, 0, 1, 1, 1, 0, -1};
    localparam int DC [9] = '{0, 0, 1, 1, 1, 0, -1, -1, -1};

    logic              clk;
    logic              rst;
    logic              cfg_strobe;
    cfg_t              cfg;
    logic [CELLS-1:0]  barriers;
    logic [ADDR_W-1:0] obs_addr;
    dist_vec_t         obs_data;
    logic              busy;
    logic              step_done;
    step_cnt_t         step_count;

    logic [31:0] lfsr_state;
    int          cycle_count = 0;

    // Reference model holding both banks of every cell
    dist_t [8:0] model_bank [2][CELLS];
    int          model_sel;

    lbm_top #(.GRID_W(GRID_W), .GRID_H(GRID_H), .ADDR_W(ADDR_W)) i_dut (
        .clk        (clk),
        .rst        (rst),
        .cfg_strobe (cfg_strobe),
        .cfg        (cfg),
        .barriers   (barriers),
        .obs_addr   (obs_addr),
        .obs_data   (obs_data),
        .busy       (busy),
        .step_done  (step_done),
        .step_count (step_count)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAIL");
            $fatal(1, "timeout");
        end
    end

    ////////////////////////////////////////
    // Random source
    ////////////////////////////////////////

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0])
        begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic random_vec(output dist_vec_t vec);
        dist_t [8:0] vals;
        logic [31:0] bits;
        for (int d = 0; d < 9; d++)
        begin
            draw_bits(16, bits);
            vals[d] = bits[15:0];
        end
        vec = vals;
    endtask

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////

    task automatic compare_dist(input string name, input dist_vec_t got, input dist_vec_t exp);
        if (got !== exp)
        begin
            $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "distribution mismatch");
        end
    endtask

    task automatic compare_count(input string name, input step_cnt_t got, input step_cnt_t exp);
        if (got !== exp)
        begin
            $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "count mismatch");
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "flag mismatch");
        end
    endtask

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    function automatic int opposite(input int d);
        return (d == 0) ? 0 : ((d + 3) % 8) + 1;
    endfunction

    task automatic model_init(input dist_vec_t vec);
        for (int a = 0; a < CELLS; a++)
        begin
            if (barriers[a])
            begin
                model_bank[0][a] = '0;
            end
            else
            begin
                model_bank[0][a] = vec;
            end
            model_bank[1][a] = model_bank[0][a];
        end
        model_sel = 0;
    endtask

    task automatic model_step();
        int          cur;
        int          nxt;
        int          a;
        int          n;
        dist_t [8:0] src;
        cur = model_sel;
        nxt = 1 - model_sel;
        // Stream from non-barrier interior cells
        for (int r = 1; r < GRID_H - 1; r++)
        begin
            for (int c = 1; c < GRID_W - 1; c++)
            begin
                a = r * GRID_W + c;
                for (int d = 0; d < 9; d++)
                begin
                    n = (r + DR[d]) * GRID_W + c + DC[d];
                    if (!barriers[a])
                    begin
                        model_bank[nxt][n][d] = model_bank[cur][a][d];
                    end
                end
            end
        end
        // Barriers in the inner region reflect into their neighbors
        for (int r = 2; r < GRID_H - 2; r++)
        begin
            for (int c = 2; c < GRID_W - 2; c++)
            begin
                a = r * GRID_W + c;
                src = model_bank[nxt][a];
                for (int d = 1; d < 9; d++)
                begin
                    n = (r + DR[d]) * GRID_W + c + DC[d];
                    if (barriers[a])
                    begin
                        model_bank[nxt][n][d] = src[opposite(d)];
                    end
                end
            end
        end
        for (int z = 0; z < CELLS; z++)
        begin
            if (barriers[z])
            begin
                model_bank[nxt][z] = '0;
            end
        end
        model_sel = nxt;
    endtask

    ////////////////////////////////////////
    // Bus helpers
    ////////////////////////////////////////

    task automatic read_cell(input int a, output dist_vec_t val);
        @(posedge clk);
        obs_addr <= ADDR_W'(a);
        @(posedge clk);
        @(negedge clk);
        val = obs_data;
    endtask

    task automatic check_grid();
        dist_vec_t got;
        dist_vec_t exp;
        for (int a = 0; a < CELLS; a++)
        begin
            read_cell(a, got);
            exp = model_bank[model_sel][a];
            compare_dist($sformatf("obs_data[%0d]", a), got, exp);
        end
    endtask

    // Strobe a configuration and count step_done pulses until busy falls
    task automatic load_and_run(input dist_vec_t vec, input step_cnt_t target,
                                input int late_at);
        int cycles;
        int pulses;
        @(posedge clk);
        cfg_strobe       <= 1'b1;
        cfg.init_vec     <= vec;
        cfg.step_target  <= target;
        @(posedge clk);
        cfg_strobe <= 1'b0;
        pulses = 0;
        cycles = 0;
        @(negedge clk);
        compare_flag("busy", busy, 1'b1);
        while (busy)
        begin
            @(posedge clk);
            cfg_strobe      <= (cycles == late_at);
            cfg.step_target <= target + 16'd4;
            @(negedge clk);
            if (cycles == late_at)
            begin
                compare_flag("busy", busy, 1'b1);
            end
            if (step_done)
            begin
                pulses++;
            end
            cycles++;
        end
        repeat (4)
        begin
            @(negedge clk);
            compare_flag("step_done", step_done, 1'b0);
            compare_flag("busy", busy, 1'b0);
        end
        compare_count("step_done pulses", step_cnt_t'(pulses), target);
        compare_count("step_count", step_count, target);
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////

    task automatic test_reset();
        repeat (4)
        begin
            @(negedge clk);
            compare_flag("busy", busy, 1'b0);
            compare_flag("step_done", step_done, 1'b0);
            compare_count("step_count", step_count, 16'd0);
        end
    endtask

    task automatic test_init();
        logic [CELLS-1:0] bar;
        logic [31:0]      bits;
        dist_vec_t        vec;
        for (int a = 0; a < CELLS; a++)
        begin
            draw_bits(3, bits);
            bar[a] = (bits[2:0] == 3'b000);
        end
        random_vec(vec);
        @(posedge clk);
        barriers <= bar;
        load_and_run(vec, 16'd0, -1);
        model_init(vec);
        check_grid();
    endtask

    task automatic test_free_stream();
        dist_vec_t vec;
        random_vec(vec);
        @(posedge clk);
        barriers <= '0;
        load_and_run(vec, 16'd1, -1);
        model_init(vec);
        model_step();
        check_grid();
    endtask

    task automatic test_bounce();
        dist_vec_t vec;
        dist_vec_t got;
        random_vec(vec);
        @(posedge clk);
        barriers <= '0;
        barriers[3 * GRID_W + 3] <= 1'b1;
        load_and_run(vec, 16'd1, -1);
        read_cell(3 * GRID_W + 3, got);
        compare_dist("obs_data[barrier]", got, '0);
        model_init(vec);
        model_step();
        check_grid();
    endtask

    task automatic test_step_target();
        dist_vec_t vec;
        random_vec(vec);
        @(posedge clk);
        barriers <= '0;
        barriers[4 * GRID_W + 2] <= 1'b1;
        // Second strobe lands mid-run and must be dropped
        load_and_run(vec, 16'd3, 150);
        model_init(vec);
        repeat (3)
        begin
            model_step();
        end
        check_grid();
    endtask

    initial
    begin
        rst        = 1'b0;
        cfg_strobe = 1'b0;
        cfg        = '0;
        barriers   = '0;
        obs_addr   = '0;
        lfsr_state = 32'h117b;
        repeat (2) @(posedge clk);
        rst <= 1'b1;

        test_reset();
        test_init();
        test_free_stream();
        test_bounce();
        test_step_target();

        $display("TEST PASS");
        $finish;
    end

endmodule

//--- tests/lbm_tb_sva.sv
`timescale 1ns/1ps

module lbm_seq_sva (
    input logic                clk,
    input logic                rst,
    input logic                busy,
    input logic                step_done,
    input lbm_pkg::map_op_e    map_op
);
    import lbm_pkg::*;

    // A step ends in one SWAP cycle
    step_done_single: assert property (
        @(posedge clk) disable iff (!rst) step_done |=> !step_done
    ) else $error("step_done stayed high for a second cycle");

    // Sequencer comes out of reset idle
    busy_low_in_reset: assert property (
        @(posedge clk) !rst |-> !busy
    ) else $error("busy high while in reset");

    busy_low_after_reset: assert property (
        @(posedge clk) $rose(rst) |-> !busy
    ) else $error("busy high on release of reset");

    // The write enables rise the cycle after the map operation
    write_only_when_busy: assert property (
        @(posedge clk) disable iff (!rst) (map_op != MAP_NONE) |=> busy
    ) else $error("memory write issued while not busy");

endmodule

bind lbm_sequencer lbm_seq_sva i_seq_sva (
    .clk       (clk),
    .rst       (rst),
    .busy      (busy),
    .step_done (step_done),
    .map_op    (map_op)
);
